/* source/rvCorePkg.sv */
package rvCorePkg;

	localparam int xlen = 32; // Data and address width

	// RV32I major opcodes handled by this slice
	typedef enum logic [6:0] {
		opcOp    = 7'b0110011, // Register-register ALU
		opcOpImm = 7'b0010011, // Register-immediate ALU
		opcLui   = 7'b0110111,
		opcAuipc = 7'b0010111,
		opcJal   = 7'b1101111,
		opcJalr  = 7'b1100111,
		opcBranch = 7'b1100011 // Conditional branches
	} opcode_e;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,   // Signed compare
		aluSltu,  // Unsigned compare
		aluXor,
		aluSrl,
		aluSra,   // Arithmetic right shift
		aluOr,
		aluAnd,
		aluPassB  // Operand B straight through
	} aluOp_e;

	typedef enum logic [1:0] {
		selRs1,
		selPc,
		selZero
	} opASel_e;

	typedef enum logic {
		selRs2,
		selImm
	} opBSel_e;

	// Control flow class of an instruction
	typedef enum logic [1:0] {
		ctrlNone,
		ctrlBranch,
		ctrlJal,
		ctrlJalr
	} ctrlKind_e;

	// One instruction word seen through each base format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;    // imm[11:0], shamt in low bits
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
		struct packed {
			logic [6:0] immHi;   // imm[11:5]
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] immLo;   // imm[4:0]
			logic [6:0] opcode;
		} s;
		struct packed {
			logic       imm12;
			logic [5:0] imm10to5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4to1;
			logic       imm11;
			logic [6:0] opcode;
		} b;
		struct packed {
			logic [19:0] imm;    // imm[31:12]
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u;
		struct packed {
			logic       imm20;
			logic [9:0] imm10to1;
			logic       imm11;
			logic [7:0] imm19to12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} rvInstr_u;

endpackage

/* source/decodeBus.sv */
`timescale 1ns/100ps

interface decodeBus;
	import rvCorePkg::*;

	logic               valid;       // Bubble when low
	logic [xlen-1:0]    pc;
	aluOp_e             aluOp;
	opASel_e            opASel;
	opBSel_e            opBSel;
	ctrlKind_e          ctrl;
	logic [2:0]         branchFunct; // funct3 of a branch
	logic [xlen-1:0]    imm;         // Sign extended immediate
	logic [4:0]         rs1;
	logic [4:0]         rs2;
	logic [4:0]         rd;
	logic               we;          // Writes rd
	logic               illegal;

	// Decode side drives everything
	modport producer (
		output valid, pc, aluOp, opASel, opBSel, ctrl, branchFunct,
		output imm, rs1, rs2, rd, we, illegal
	);

	// Execute side only reads
	modport consumer (
		input valid, pc, aluOp, opASel, opBSel, ctrl, branchFunct,
		input imm, rs1, rs2, rd, we, illegal
	);

endinterface

/* source/fetchStage.sv */
`timescale 1ns/100ps

module fetchStage #(
	parameter logic [rvCorePkg::xlen-1:0] resetPc = '0
) (
	input  logic                        clk,
	input  logic                        nrst,
	input  logic                        instrValid,
	input  logic [31:0]                 instrIn,
	input  logic                        stall,
	output logic                        fetchValid,
	output logic [rvCorePkg::xlen-1:0]  fetchPc,
	output logic [31:0]                 fetchInstr
);
	import rvCorePkg::*;

	logic [xlen-1:0] pc;       // Address of the next accepted word
	logic            accept;

	assign accept = instrValid && !stall; // Word taken this cycle

	// Program counter and valid flag
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pc         <= resetPc;
			fetchValid <= 1'b0;
		end
		else if (!stall)
		begin
			fetchValid <= instrValid; // Bubble when nothing offered
			if (accept)
				pc <= pc + xlen'(4);
		end
	end

	// Word and its address, held during a stall
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			fetchInstr <= instrIn;
			fetchPc    <= pc;
		end
	end

endmodule

/* source/instrDecoder.sv */
`timescale 1ns/100ps

module instrDecoder (
	input  logic [6:0]            opcode,
	input  logic [2:0]            funct3,
	input  logic [6:0]            funct7,
	output rvCorePkg::aluOp_e     aluOp,
	output rvCorePkg::opASel_e    opASel,
	output rvCorePkg::opBSel_e    opBSel,
	output rvCorePkg::ctrlKind_e  ctrl,
	output logic                  we,
	output logic                  illegal
);
	import rvCorePkg::*;

	logic f7Zero; // funct7 all zero
	logic f7Alt;  // Only bit 5 set, sub and sra

	assign f7Zero = (funct7 == 7'b0000000);
	assign f7Alt  = (funct7 == 7'b0100000);

	always_comb
	begin
		// Defaults, a plain register op
		aluOp   = aluAdd;
		opASel  = selRs1;
		opBSel  = selRs2;
		ctrl    = ctrlNone;
		we      = 1'b0;
		illegal = 1'b0;

		case (opcode)
			opcOp:
			begin
				we = 1'b1;
				case (funct3)
					3'b000: if (f7Alt) aluOp = aluSub;
					        else if (f7Zero) aluOp = aluAdd;
					        else illegal = 1'b1;
					3'b001: aluOp = aluSll;
					3'b010: aluOp = aluSlt;
					3'b011: aluOp = aluSltu;
					3'b100: aluOp = aluXor;
					3'b101: if (f7Alt) aluOp = aluSra;
					        else if (f7Zero) aluOp = aluSrl;
					        else illegal = 1'b1;
					3'b110: aluOp = aluOr;
					default: aluOp = aluAnd;
				endcase
				// Only add/sub and the right shifts accept the alternate funct7
				if (funct3 != 3'b000 && funct3 != 3'b101 && !f7Zero)
					illegal = 1'b1;
			end
			opcOpImm:
			begin
				we     = 1'b1;
				opBSel = selImm;
				case (funct3)
					3'b000: aluOp = aluAdd;
					3'b001:
					begin
						aluOp = aluSll;
						if (!f7Zero)
							illegal = 1'b1; // slli upper bits must be zero
					end
					3'b010: aluOp = aluSlt;
					3'b011: aluOp = aluSltu;
					3'b100: aluOp = aluXor;
					3'b101: if (f7Alt) aluOp = aluSra; // srai
					        else if (f7Zero) aluOp = aluSrl;
					        else illegal = 1'b1;
					3'b110: aluOp = aluOr;
					default: aluOp = aluAnd;
				endcase
			end
			opcLui:
			begin
				we     = 1'b1;
				opASel = selZero; // 0 + imm
				opBSel = selImm;
			end
			opcAuipc:
			begin
				we     = 1'b1;
				opASel = selPc;   // pc + imm
				opBSel = selImm;
			end
			opcJal:
			begin
				we     = 1'b1;    // Link pc+4
				ctrl   = ctrlJal;
				opASel = selPc;
				opBSel = selImm;
			end
			opcJalr:
			begin
				we     = 1'b1;
				ctrl   = ctrlJalr;
				opBSel = selImm;  // ALU forms rs1 + imm
				if (funct3 != 3'b000)
					illegal = 1'b1;
			end
			opcBranch:
			begin
				ctrl  = ctrlBranch; // Compare done in execute
				aluOp = aluSub;
				if (funct3 == 3'b010 || funct3 == 3'b011)
					illegal = 1'b1; // No branch encoding there
			end
			default: illegal = 1'b1; // Loads, stores, system, M ext
		endcase

		// Illegal words never write or redirect
		if (illegal)
		begin
			we   = 1'b0;
			ctrl = ctrlNone;
		end
	end

endmodule

/* source/decodeStage.sv */
`timescale 1ns/100ps

module decodeStage (
	input  logic                        clk,
	input  logic                        nrst,
	input  logic                        fetchValid,
	input  logic [rvCorePkg::xlen-1:0]  fetchPc,
	input  logic [31:0]                 fetchInstr,
	input  logic                        stall,
	decodeBus.producer                  bus
);
	import rvCorePkg::*;

	logic            validReg;
	logic [xlen-1:0] pcReg;
	rvInstr_u        instrReg;  // Word viewed in all formats

	logic [xlen-1:0] iImm;
	logic [xlen-1:0] sImm;
	logic [xlen-1:0] bImm;
	logic [xlen-1:0] uImm;
	logic [xlen-1:0] jImm;
	logic [xlen-1:0] immSel;

	aluOp_e    decAluOp;
	opASel_e   decOpASel;
	opBSel_e   decOpBSel;
	ctrlKind_e decCtrl;
	logic      decWe;
	logic      decIllegal;

	// Pipe register valid
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			validReg <= 1'b0;
		else if (!stall)
			validReg <= fetchValid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			instrReg <= fetchInstr;
			pcReg    <= fetchPc;
		end
	end

	// Immediates, sign taken from bit 31 in every format
	assign iImm = {{20{instrReg.i.imm[11]}}, instrReg.i.imm};
	assign sImm = {{20{instrReg.s.immHi[6]}}, instrReg.s.immHi, instrReg.s.immLo};
	assign bImm = {{19{instrReg.b.imm12}}, instrReg.b.imm12, instrReg.b.imm11,
	               instrReg.b.imm10to5, instrReg.b.imm4to1, 1'b0};
	assign uImm = {instrReg.u.imm, 12'b0};
	assign jImm = {{11{instrReg.j.imm20}}, instrReg.j.imm20, instrReg.j.imm19to12,
	               instrReg.j.imm11, instrReg.j.imm10to1, 1'b0};

	always_comb
	begin
		case (instrReg.r.opcode)
			opcOpImm, opcJalr, opcOp: immSel = iImm; // OP ignores it
			opcBranch:                immSel = bImm;
			opcLui, opcAuipc:         immSel = uImm;
			opcJal:                   immSel = jImm;
			default:                  immSel = sImm; // S layout otherwise
		endcase
	end

	instrDecoder i_instrDecoder (
		.opcode  (instrReg.r.opcode),
		.funct3  (instrReg.r.funct3),
		.funct7  (instrReg.r.funct7),
		.aluOp   (decAluOp),
		.opASel  (decOpASel),
		.opBSel  (decOpBSel),
		.ctrl    (decCtrl),
		.we      (decWe),
		.illegal (decIllegal)
	);

	assign bus.valid       = validReg;
	assign bus.pc          = pcReg;
	assign bus.aluOp       = decAluOp;
	assign bus.opASel      = decOpASel;
	assign bus.opBSel      = decOpBSel;
	assign bus.ctrl        = decCtrl;
	assign bus.branchFunct = instrReg.b.funct3;
	assign bus.imm         = immSel;
	assign bus.rs1         = instrReg.r.rs1;
	assign bus.rs2         = instrReg.r.rs2;
	assign bus.rd          = instrReg.r.rd;
	assign bus.we          = decWe;
	assign bus.illegal     = decIllegal;

endmodule

/* source/executeStage.sv */
`timescale 1ns/100ps

module executeStage (
	input  logic                        clk,
	input  logic                        nrst,
	input  logic                        stall,
	decodeBus.consumer                  bus,
	output logic                        retireValid,
	output logic [rvCorePkg::xlen-1:0]  retirePc,
	output logic [4:0]                  retireRd,
	output logic                        retireWe,
	output logic [rvCorePkg::xlen-1:0]  retireData,
	output logic                        retireIllegal,
	output logic                        redirect,
	output logic [rvCorePkg::xlen-1:0]  redirectTarget
);
	import rvCorePkg::*;

	logic [xlen-1:0] regFile [32];  // x0 stays zero

	// Retire register
	logic            validReg;
	logic            weReg;
	logic            illegalReg;
	logic            redirectReg;
	logic [xlen-1:0] pcReg;
	logic [4:0]      rdReg;
	logic [xlen-1:0] dataReg;
	logic [xlen-1:0] targetReg;

	logic            fwdA;
	logic            fwdB;
	logic [xlen-1:0] rs1Val;
	logic [xlen-1:0] rs2Val;
	logic [xlen-1:0] opA;
	logic [xlen-1:0] opB;
	logic [xlen-1:0] aluResult;
	logic            cmpTrue;   // Branch condition holds
	logic            isJump;
	logic            taken;
	logic [xlen-1:0] target;
	logic [xlen-1:0] wbData;

	// Register file write one edge after retire
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int k = 0; k < 32; k++)
				regFile[k] <= '0;
		end
		else if (validReg && weReg && rdReg != 5'd0)
			regFile[rdReg] <= dataReg;
	end

	// Previous result bypasses the file
	assign fwdA   = validReg && weReg && (rdReg == bus.rs1);
	assign fwdB   = validReg && weReg && (rdReg == bus.rs2);
	assign rs1Val = (bus.rs1 == 5'd0) ? '0 : (fwdA ? dataReg : regFile[bus.rs1]);
	assign rs2Val = (bus.rs2 == 5'd0) ? '0 : (fwdB ? dataReg : regFile[bus.rs2]);

	always_comb
	begin
		case (bus.opASel)
			selPc:   opA = bus.pc;
			selZero: opA = '0;
			default: opA = rs1Val;
		endcase
	end

	assign opB = (bus.opBSel == selImm) ? bus.imm : rs2Val;

	always_comb
	begin
		case (bus.aluOp)
			aluAdd:   aluResult = opA + opB;
			aluSub:   aluResult = opA - opB;
			aluSll:   aluResult = opA << opB[4:0];
			aluSlt:   aluResult = xlen'($signed(opA) < $signed(opB));
			aluSltu:  aluResult = xlen'(opA < opB);
			aluXor:   aluResult = opA ^ opB;
			aluSrl:   aluResult = opA >> opB[4:0];
			aluSra:   aluResult = $unsigned($signed(opA) >>> opB[4:0]);
			aluOr:    aluResult = opA | opB;
			aluAnd:   aluResult = opA & opB;
			aluPassB: aluResult = opB;
			default:  aluResult = '0;
		endcase
	end

	// Branch compare on the register values
	always_comb
	begin
		case (bus.branchFunct)
			3'b000:  cmpTrue = (rs1Val == rs2Val);                   // beq
			3'b001:  cmpTrue = (rs1Val != rs2Val);                   // bne
			3'b100:  cmpTrue = ($signed(rs1Val) < $signed(rs2Val));  // blt
			3'b101:  cmpTrue = ($signed(rs1Val) >= $signed(rs2Val)); // bge
			3'b110:  cmpTrue = (rs1Val < rs2Val);                    // bltu
			3'b111:  cmpTrue = (rs1Val >= rs2Val);                   // bgeu
			default: cmpTrue = 1'b0;
		endcase
	end

	assign isJump = (bus.ctrl == ctrlJal) || (bus.ctrl == ctrlJalr);
	assign taken  = isJump || (bus.ctrl == ctrlBranch && cmpTrue);
	// JALR target is the ALU sum with bit 0 cleared
	assign target = (bus.ctrl == ctrlJalr) ? {aluResult[xlen-1:1], 1'b0} : bus.pc + bus.imm;
	assign wbData = isJump ? bus.pc + xlen'(4) : aluResult; // Link value for jumps

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			validReg    <= 1'b0;
			weReg       <= 1'b0;
			illegalReg  <= 1'b0;
			redirectReg <= 1'b0;
		end
		else if (!stall)
		begin
			validReg    <= bus.valid;
			weReg       <= bus.valid && bus.we;
			illegalReg  <= bus.valid && bus.illegal;
			redirectReg <= bus.valid && taken;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			pcReg     <= bus.pc;
			rdReg     <= bus.rd;
			dataReg   <= wbData;
			targetReg <= target;
		end
	end

	// Held result shown once, in its first unstalled cycle
	assign retireValid    = validReg && !stall;
	assign redirect       = redirectReg && !stall;
	assign retirePc       = pcReg;
	assign retireRd       = rdReg;
	assign retireWe       = weReg;
	assign retireData     = dataReg;
	assign retireIllegal  = illegalReg;
	assign redirectTarget = targetReg;

endmodule

/* source/rvPipeTop.sv */
`timescale 1ns/100ps

module rvPipeTop #(
	parameter logic [rvCorePkg::xlen-1:0] resetPc = '0
) (
	input  logic                        clk,
	input  logic                        nrst,
	input  logic                        instrValid,
	input  logic [31:0]                 instrIn,
	input  logic                        stall,
	output logic                        retireValid,
	output logic [rvCorePkg::xlen-1:0]  retirePc,
	output logic [4:0]                  retireRd,
	output logic                        retireWe,
	output logic [rvCorePkg::xlen-1:0]  retireData,
	output logic                        retireIllegal,
	output logic                        redirect,
	output logic [rvCorePkg::xlen-1:0]  redirectTarget
);
	import rvCorePkg::*;

	logic            fetchValid;
	logic [xlen-1:0] fetchPc;
	logic [31:0]     fetchInstr;

	decodeBus decBus (); // Decode to execute

	fetchStage #(
		.resetPc (resetPc)
	) i_fetchStage (
		.clk        (clk),
		.nrst       (nrst),
		.instrValid (instrValid),
		.instrIn    (instrIn),
		.stall      (stall),
		.fetchValid (fetchValid),
		.fetchPc    (fetchPc),
		.fetchInstr (fetchInstr)
	);

	decodeStage i_decodeStage (
		.clk        (clk),
		.nrst       (nrst),
		.fetchValid (fetchValid),
		.fetchPc    (fetchPc),
		.fetchInstr (fetchInstr),
		.stall      (stall),
		.bus        (decBus.producer)
	);

	executeStage i_executeStage (
		.clk            (clk),
		.nrst           (nrst),
		.stall          (stall),
		.bus            (decBus.consumer),
		.retireValid    (retireValid),
		.retirePc       (retirePc),
		.retireRd       (retireRd),
		.retireWe       (retireWe),
		.retireData     (retireData),
		.retireIllegal  (retireIllegal),
		.redirect       (redirect),
		.redirectTarget (redirectTarget)
	);

endmodule

/* bench/rvPipeBench.sv */
`timescale 1ns/100ps

module rvPipeBench;
	import rvCorePkg::*;

	localparam int          clkPeriod = 4;              // ns
	localparam int          numWords  = 2000;
	localparam logic [31:0] resetPc   = 32'h0000_1000;
	localparam int          timeoutNs = numWords * 4 * clkPeriod;

	// One expected retirement
	typedef struct packed {
		logic [31:0] pc;
		logic [4:0]  rd;
		logic        we;
		logic [31:0] data;
		logic        illegal;
		logic        redirect;
		logic [31:0] target;
	} expRetire_t;

	logic        clk;
	logic        nrst;
	logic        instrValid;
	logic [31:0] instrIn;
	logic        stall;
	logic        retireValid;
	logic [31:0] retirePc;
	logic [4:0]  retireRd;
	logic        retireWe;
	logic [31:0] retireData;
	logic        retireIllegal;
	logic        redirect;
	logic [31:0] redirectTarget;

	logic [31:0] rngState = 32'h3826_bd5a;
	logic [31:0] modelRegs [32]; // Architectural state of the model
	logic [31:0] modelPc;
	expRetire_t  expQ [$];       // In program order
	int          errorCount  = 0;
	int          checkCount  = 0;
	int          retireCount = 0;
	int          acceptCount = 0;

	rvPipeTop #(
		.resetPc (resetPc)
	) i_rvPipeTop (
		.clk            (clk),
		.nrst           (nrst),
		.instrValid     (instrValid),
		.instrIn        (instrIn),
		.stall          (stall),
		.retireValid    (retireValid),
		.retirePc       (retirePc),
		.retireRd       (retireRd),
		.retireWe       (retireWe),
		.retireData     (retireData),
		.retireIllegal  (retireIllegal),
		.redirect       (redirect),
		.redirectTarget (redirectTarget)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function logic [31:0] nextRandom();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	function logic chance(input int pct);
		return (nextRandom() % 100) < pct;
	endfunction

	// Random word, registers limited to x0..x7
	function logic [31:0] makeInstr();
		rvInstr_u    w;
		logic [31:0] r;
		logic [2:0]  f3;
		int          kind;
		w    = rvInstr_u'(nextRandom()); // Random immediates and spare bits
		r    = nextRandom();
		kind = int'(nextRandom() % 100);
		f3   = w.r.funct3;
		w.r.rd = {2'b00, r[10:8]};
		if (kind < 5)
		begin
			case (r[19:18])
				2'd0: w.r.opcode = 7'b0000011; // Load
				2'd1: w.r.opcode = 7'b0100011; // Store
				2'd2: w.r.opcode = 7'b1110011; // System
				default: w.r.opcode = 7'b0001111; // Fence
			endcase
		end
		else if (kind < 25)
		begin
			w.r.opcode = opcOp;
			w.r.rs1    = {2'b00, r[13:11]};
			w.r.rs2    = {2'b00, r[16:14]};
			w.r.funct7 = ((f3 == 3'b000 || f3 == 3'b101) && r[17]) ? 7'b0100000 : 7'b0000000;
		end
		else if (kind < 45)
		begin
			w.i.opcode = opcOpImm;
			w.i.rs1    = {2'b00, r[13:11]};
			if (f3 == 3'b001)
				w.r.funct7 = 7'b0000000;                        // slli
			else if (f3 == 3'b101)
				w.r.funct7 = r[17] ? 7'b0100000 : 7'b0000000;   // srai or srli
		end
		else if (kind < 52)
			w.u.opcode = opcLui;
		else if (kind < 59)
			w.u.opcode = opcAuipc;
		else if (kind < 67)
			w.j.opcode = opcJal;
		else if (kind < 75)
		begin
			w.i.opcode = opcJalr;
			w.i.funct3 = 3'b000;
			w.i.rs1    = {2'b00, r[13:11]};
		end
		else
		begin
			w.b.opcode = opcBranch;
			w.b.rs1    = {2'b00, r[13:11]};
			w.b.rs2    = {2'b00, r[16:14]};
			if (f3[2:1] == 2'b01)
				w.b.funct3 = {1'b1, f3[1:0]}; // Skip the two unused encodings
		end
		return w;
	endfunction

	// Integer ops by funct3, alt selects sub and sra
	function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return {31'b0, $signed(a) < $signed(b)};
			3'b011: return {31'b0, a < b};
			3'b100: return a ^ b;
			3'b101:
				if (alt)
					return $unsigned($signed(a) >>> b[4:0]);
				else
					return a >> b[4:0];
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	// ISA reference, one accepted word at a time
	task automatic modelExecute(input logic [31:0] word);
		rvInstr_u    w;
		expRetire_t  e;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immI;
		logic [31:0] immB;
		logic [31:0] immU;
		logic [31:0] immJ;
		w    = rvInstr_u'(word);
		a    = modelRegs[w.r.rs1];
		b    = modelRegs[w.r.rs2];
		immI = {{20{word[31]}}, word[31:20]};
		immB = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
		immU = {word[31:12], 12'h000};
		immJ = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
		e    = '0;
		e.pc = modelPc;
		e.rd = w.r.rd;
		case (w.r.opcode)
			opcOp:
			begin
				e.we      = 1'b1;
				e.illegal = !(w.r.funct7 == 7'h00 || (w.r.funct7 == 7'h20 &&
					(w.r.funct3 == 3'b000 || w.r.funct3 == 3'b101)));
				e.data    = aluRef(w.r.funct3, w.r.funct7[5], a, b);
			end
			opcOpImm:
			begin
				e.we = 1'b1;
				if (w.r.funct3 == 3'b001)
					e.illegal = (w.r.funct7 != 7'h00);
				else if (w.r.funct3 == 3'b101)
					e.illegal = (w.r.funct7 != 7'h00) && (w.r.funct7 != 7'h20);
				e.data = aluRef(w.r.funct3, (w.r.funct3 == 3'b101) && w.r.funct7[5], a, immI);
			end
			opcLui:
			begin
				e.we   = 1'b1;
				e.data = immU;
			end
			opcAuipc:
			begin
				e.we   = 1'b1;
				e.data = modelPc + immU;
			end
			opcJal:
			begin
				e.we       = 1'b1;
				e.data     = modelPc + 32'd4; // Link
				e.redirect = 1'b1;
				e.target   = modelPc + immJ;
			end
			opcJalr:
			begin
				e.illegal  = (w.i.funct3 != 3'b000);
				e.we       = 1'b1;
				e.data     = modelPc + 32'd4;
				e.redirect = 1'b1;
				e.target   = (a + immI) & ~32'd1;
			end
			opcBranch:
			begin
				e.target = modelPc + immB;
				case (w.b.funct3)
					3'b000: e.redirect = (a == b);
					3'b001: e.redirect = (a != b);
					3'b100: e.redirect = ($signed(a) < $signed(b));
					3'b101: e.redirect = ($signed(a) >= $signed(b));
					3'b110: e.redirect = (a < b);
					3'b111: e.redirect = (a >= b);
					default: e.illegal = 1'b1;
				endcase
			end
			default: e.illegal = 1'b1; // Everything outside the slice
		endcase
		if (e.illegal)
		begin
			e.we       = 1'b0;
			e.redirect = 1'b0;
		end
		if (e.we && e.rd != 5'd0)
			modelRegs[e.rd] = e.data;
		modelPc = modelPc + 32'd4;
		expQ.push_back(e);
	endtask

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
		checkCount++;
		if (got !== want)
		begin
			errorCount++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h at retirement %0d",
				name, got, want, retireCount);
		end
	endtask

	// Retire monitor, outputs settled since the falling edge
	always @(posedge clk)
	begin
		expRetire_t e;
		if (nrst)
		begin
			if ($isunknown({retireValid, redirect}))
			begin
				errorCount++;
				$display("Retire strobes are unknown at %0t", $time);
			end
			if (redirect && !retireValid)
			begin
				errorCount++;
				$display("Redirect raised without a retirement at %0t", $time);
			end
			if (retireValid)
			begin
				if (expQ.size() == 0)
				begin
					errorCount++;
					$display("Unexpected retirement of pc 0x%h with nothing outstanding", retirePc);
				end
				else
				begin
					e = expQ.pop_front();
					checkValue("retirePc", retirePc, e.pc);
					checkValue("retireWe", 32'(retireWe), 32'(e.we));
					checkValue("retireIllegal", 32'(retireIllegal), 32'(e.illegal));
					checkValue("redirect", 32'(redirect), 32'(e.redirect));
					if (e.we)
					begin
						checkValue("retireRd", 32'(retireRd), 32'(e.rd));
						checkValue("retireData", retireData, e.data);
					end
					if (e.redirect)
						checkValue("redirectTarget", redirectTarget, e.target);
					retireCount++;
				end
			end
		end
	end

	initial
	begin
		#(timeoutNs);
		$display("Watchdog expired after %0d ns, %0d retirements outstanding",
			timeoutNs, expQ.size());
		$display("errors %0d, checks %0d, retirements %0d", errorCount, checkCount, retireCount);
		$display("test failed");
		$finish;
	end

	initial
	begin
		nrst       = 1'b0;
		instrValid = 1'b0;
		instrIn    = '0;
		stall      = 1'b0;
		modelPc    = resetPc;
		for (int k = 0; k < 32; k++)
			modelRegs[k] = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;

		while (acceptCount < numWords)
		begin
			@(negedge clk);
			stall      = chance(15);
			instrValid = chance(80);
			instrIn    = instrValid ? makeInstr() : nextRandom(); // Garbage when idle
			if (instrValid && !stall)
			begin
				modelExecute(instrIn); // Taken at the coming rising edge
				acceptCount++;
			end
		end
		@(negedge clk);
		instrValid = 1'b0;
		stall      = 1'b0;

		// Drain, then a few idle edges to catch stray retirements
		while (expQ.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);

		$display("errors %0d, checks %0d, retirements %0d of %0d",
			errorCount, checkCount, retireCount, numWords);
		if (errorCount == 0 && retireCount == numWords)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* list.f */
source/rvCorePkg.sv
source/decodeBus.sv
source/fetchStage.sv
source/instrDecoder.sv
source/decodeStage.sv
source/executeStage.sv
source/rvPipeTop.sv
bench/rvPipeBench.sv

/* Makefile */
# Verilator build and run of the RV32I pipeline slice

TOP       ?= rvPipeBench
BUILD_DIR ?= build
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary

SOURCES := $(wildcard source/*.sv bench/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM): list.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f list.f --Mdir $(BUILD_DIR) -o V$(TOP)

test: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^test passed$$" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
